//--- soc_interconnect.f
+incdir+include
source/interconnect_pkg.sv
source/access_decoder.sv
source/dram_load_aligner.sv
source/read_response_mux.sv
source/tohost_mailbox.sv
source/soc_interconnect.sv
tests/tb_soc_interconnect.sv

//--- include/tb_interconnect_tasks.svh
/* Directed test tasks of the interconnect testbench, included inside the
   testbench module where they see its signals and helpers */
`ifndef TB_INTERCONNECT_TASKS_SVH
`define TB_INTERCONNECT_TASKS_SVH

// Bytes from the line starting at the offset, zero past the line end, then extended
function automatic data_t expected_load(line_t line, logic [3:0] off, ld_ctrl_t ctrl);
    data_t w;
    int    j;
    w = '0;
    for (j = 0; j < 4; j++) begin
        if (int'(off) + j < 16) begin
            w[8*j +: 8] = line[(int'(off) + j)*8 +: 8];
        end
    end
    if (ctrl[1:0] == 2'd0) begin
        w = {{24{w[7] & !ctrl[2]}}, w[7:0]};
    end else if (ctrl[1:0] == 2'd1) begin
        w = {{16{w[15] & !ctrl[2]}}, w[15:0]};
    end
    return w;
endfunction

task automatic store_to_dram();
    addr_t addrs [2];
    int    start;
    int    i;
    start    = errors;
    addrs[0] = 32'h0123_4568;
    addrs[1] = 32'h8abc_def0;
    for (i = 0; i < 2; i++) begin
        present_request(make_req(addrs[i], 32'hdead_beef ^ addrs[i], 1'b1, 1'b0, FUNCT3_SW));
        check_equal("dram_cmd.wr_en", dram_cmd.wr_en, 1'b1);
        check_equal("dram_cmd.addr", dram_cmd.addr, {5'b0, addrs[i][26:0]});
        check_equal("dram_cmd.wdata", dram_cmd.wdata, 32'hdead_beef ^ addrs[i]);
        check_equal("dram_cmd.ctrl", dram_cmd.ctrl, FUNCT3_SW);
        check_equal("slot_we/plic_we/clint_we", {slot_we, plic_we, clint_we}, '0);
    end
    // Busy DRAM drops the enable and stalls the CPU
    @(posedge CLK);
    dram_busy <= 1'b1;
    cpu_req   <= make_req(addrs[0], 32'h1234_5678, 1'b1, 1'b0, FUNCT3_SW);
    @(negedge CLK);
    check_equal("dram_cmd.wr_en", dram_cmd.wr_en, 1'b0);
    check_equal("proc_busy", proc_busy, 1'b1);
    @(posedge CLK);
    dram_busy <= 1'b0;
    cpu_req   <= make_req('0, '0, 1'b0, 1'b0, '0);
    report_test("dram store", start);
endtask

task automatic load_from_dram();
    // lb, lbu, lh, lhu, lw from low to high
    logic [14:0] codes;
    ld_ctrl_t    ctrl;
    logic [3:0]  off;
    addr_t       addr;
    int          start;
    int          c;
    int          n;
    start = errors;
    codes = {3'b010, 3'b101, 3'b001, 3'b100, 3'b000};
    for (c = 0; c < 5; c++) begin
        for (n = 0; n < 3; n++) begin
            off  = 4'($random(seed));
            ctrl = codes[3*c +: 3];
            addr = {((c + n) % 2 == 1) ? 4'h8 : 4'h0, 24'h00_1230, off};
            present_request(make_req(addr, '0, 1'b0, 1'b1, ctrl));
            check_equal("dram_cmd.rd_en", dram_cmd.rd_en, 1'b1);
            return_to_idle();
            check_equal("load_word", load_word, expected_load(dram_line, off, ctrl));
            check_equal("is_dram", is_dram, 1'b1);
            check_equal("rdata", rdata, dram_line);
        end
    end
    report_test("dram load extraction", start);
endtask

task automatic access_slots();
    addr_t addr;
    int    start;
    int    k;
    start = errors;
    for (k = 0; k < N_SLOTS; k++) begin
        addr = {4'h4, 4'(k), 24'h00_0100 + 24'(4*k)};
        present_request(make_req(addr, 32'h600d_0000 + k, 1'b1, 1'b0, FUNCT3_SW));
        check_equal("slot_we", slot_we, (1 << k));
        check_equal("slot_offset", slot_offset, {4'h0, addr[27:0]});
        check_equal("slot_wdata", slot_wdata, 32'h600d_0000 + k);
        check_equal("dram_cmd.wr_en", dram_cmd.wr_en, 1'b0);
        present_request(make_req(addr, '0, 1'b0, 1'b1, FUNCT3_LW));
        return_to_idle();
        check_equal("rdata", rdata, {96'b0, data_t'(32'h5100_0000 + k)});
        check_equal("is_dram", is_dram, 1'b0);
    end
    // Slot 7 has no peripheral behind it
    present_request(make_req(32'h4700_0010, '0, 1'b0, 1'b1, FUNCT3_LW));
    return_to_idle();
    check_equal("rdata", rdata, '0);
    check_equal("is_dram", is_dram, 1'b0);
    report_test("slot writes and reads", start);
endtask

task automatic access_plic_clint();
    int start;
    start = errors;
    present_request(make_req(32'h5000_0004, 32'h0000_0003, 1'b1, 1'b0, FUNCT3_SW));
    check_equal("plic_we/plic_re/clint_we", {plic_we, plic_re, clint_we}, 3'b100);
    present_request(make_req(32'h5000_0008, '0, 1'b0, 1'b1, FUNCT3_LW));
    check_equal("plic_we/plic_re/clint_we", {plic_we, plic_re, clint_we}, 3'b010);
    return_to_idle();
    check_equal("rdata", rdata, {96'b0, PLIC_WORD});
    present_request(make_req(32'h6000_4000, 32'h0000_00ff, 1'b1, 1'b0, FUNCT3_SW));
    check_equal("plic_we/plic_re/clint_we", {plic_we, plic_re, clint_we}, 3'b001);
    present_request(make_req(32'h6000_bff8, '0, 1'b0, 1'b1, FUNCT3_LW));
    return_to_idle();
    check_equal("rdata", rdata, {96'b0, CLINT_WORD});
    check_equal("is_dram", is_dram, 1'b0);
    report_test("plic and clint", start);
endtask

task automatic print_via_tohost();
    logic [7:0] got_char;
    int         start;
    int         highs;
    int         first;
    int         i;
    start    = errors;
    highs    = 0;
    first    = -1;
    got_char = '0;
    @(posedge CLK);
    uart_ready <= 1'b0;
    present_request(make_req(TOHOST_ADDR, 32'h0101_0041, 1'b1, 1'b0, FUNCT3_SW));
    check_equal("proc_busy", proc_busy, 1'b1);
    @(posedge CLK);
    cpu_req <= make_req('0, '0, 1'b0, 1'b0, '0);
    // Register loads on the first edge, byte leaves on the second
    for (i = 1; i <= 8; i++) begin
        @(negedge CLK);
        if (uart_we) begin
            highs++;
            if (first < 0) begin
                first    = i;
                got_char = uart_data;
            end
        end
    end
    if (highs == 0) begin
        report_failure("no uart_we pulse within 8 cycles of the print-char store");
    end else begin
        check_equal("uart_we pulse cycle", first, 2);
        check_equal("uart_we high cycles", highs, 1);
        check_equal("uart_data", got_char, 8'h41);
    end
    @(posedge CLK);
    uart_ready <= 1'b1;
    @(negedge CLK);
    check_equal("proc_busy", proc_busy, 1'b0);
    report_test("tohost print", start);
endtask

task automatic power_off_via_tohost();
    int start;
    int rise;
    int i;
    start = errors;
    rise  = -1;
    check_equal("finish", finish, 1'b0);
    present_request(make_req(TOHOST_ADDR, 32'h0002_0000, 1'b1, 1'b0, FUNCT3_SW));
    @(posedge CLK);
    cpu_req <= make_req('0, '0, 1'b0, 1'b0, '0);
    for (i = 1; i <= 8 && rise < 0; i++) begin
        @(negedge CLK);
        if (finish) begin
            rise = i;
        end
    end
    if (rise < 0) begin
        report_failure("finish did not rise within 8 cycles of the power-off store");
    end else begin
        check_equal("finish rise cycle", rise, 2);
    end
    // Sticky until reset
    for (i = 0; i < 8; i++) begin
        @(negedge CLK);
        check_equal("finish", finish, 1'b1);
    end
    report_test("power off", start);
endtask

`endif

//--- tests/tb_soc_interconnect.sv
/* Directed testbench of the memory interconnect with DRAM, slot, PLIC and
   CLINT models; runs the tests of the included task file */
`timescale 1ns/1ns

module tb_soc_interconnect
    import interconnect_pkg::*;
();

    localparam int    N_SLOTS    = 6;
    localparam data_t PLIC_WORD  = 32'hc0de_0005;
    localparam data_t CLINT_WORD = 32'hc1c1_0006;

    logic                CLK;
    logic                arst_n;
    cpu_req_t            cpu_req;
    logic                dram_busy;
    line_t               dram_rdata;
    dram_cmd_t           dram_cmd;
    data_t               load_word;
    logic [N_SLOTS-1:0]  slot_we;
    data_t               slot_wdata;
    addr_t               slot_offset;
    data_t [N_SLOTS-1:0] slot_rdata;
    logic                plic_we;
    logic                plic_re;
    data_t               plic_rdata;
    logic                clint_we;
    data_t               clint_rdata;
    line_t               rdata;
    logic                is_dram;
    logic                uart_ready;
    logic                uart_we;
    logic [7:0]          uart_data;
    logic                finish;
    logic                proc_busy;

    // DRAM model line, kept for expected load words
    integer seed;
    line_t  dram_line;
    int     errors;
    int     tests_run;
    int     tests_failed;

    soc_interconnect #(.N_SLOTS(N_SLOTS)) u_soc_interconnect (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic cpu_req_t make_req(addr_t addr, data_t wdata, logic we, logic re,
                                          ld_ctrl_t ctrl);
        cpu_req_t r;
        r.addr  = addr;
        r.wdata = wdata;
        r.we    = we;
        r.re    = re;
        r.ctrl  = ctrl;
        return r;
    endfunction

    task automatic check_equal(string name, logic [127:0] got, logic [127:0] exp);
        assert (got === exp) else begin
            $display("error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(string what);
        $display("%s (at %0t ns)", what, $time);
        errors++;
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // Drive on the rising edge, return at the falling edge for sampling
    task automatic present_request(cpu_req_t req);
        @(posedge CLK);
        cpu_req <= req;
        @(negedge CLK);
    endtask

    task automatic return_to_idle();
        present_request(make_req('0, '0, 1'b0, 1'b0, '0));
    endtask

    `include "tb_interconnect_tasks.svh"

    initial begin
        seed         = 32'ha3882f8e;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        cpu_req      = make_req('0, '0, 1'b0, 1'b0, '0);
        dram_busy    = 1'b0;
        uart_ready   = 1'b1;
        plic_rdata   = PLIC_WORD;
        clint_rdata  = CLINT_WORD;
        for (int i = 0; i < N_SLOTS; i++) begin
            slot_rdata[i] = 32'h5100_0000 + i;
        end
        dram_line  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        dram_rdata = dram_line;
        repeat (4) @(posedge CLK);
        arst_n <= 1'b1;

        store_to_dram();
        load_from_dram();
        access_slots();
        access_plic_clint();
        print_via_tohost();
        power_off_via_tohost();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- source/soc_interconnect.sv
/* CPU-facing memory interconnect top. Connects the decoder, DRAM load aligner,
   read response mux and tohost mailbox, and forms processor busy */
`timescale 1ns/1ns

module soc_interconnect
    import interconnect_pkg::*;
#(
    parameter int N_SLOTS = 6
) (
    input  logic                 CLK,
    input  logic                 arst_n,
    // CPU data port
    input  cpu_req_t             cpu_req,
    output line_t                rdata,
    output logic                 is_dram,
    output logic                 proc_busy,
    // DRAM
    input  logic                 dram_busy,
    input  line_t                dram_rdata,
    output dram_cmd_t            dram_cmd,
    output data_t                load_word,
    // Virtio slots
    output logic [N_SLOTS-1:0]   slot_we,
    output data_t                slot_wdata,
    output addr_t                slot_offset,
    input  data_t [N_SLOTS-1:0]  slot_rdata,
    // PLIC and CLINT
    output logic                 plic_we,
    output logic                 plic_re,
    input  data_t                plic_rdata,
    output logic                 clint_we,
    input  data_t                clint_rdata,
    // UART and simulation control
    input  logic                 uart_ready,
    output logic                 uart_we,
    output logic [7:0]           uart_data,
    output logic                 finish
);

    dev_t  req_dev;
    virt_t req_virt;

    access_decoder #(.N_SLOTS(N_SLOTS)) u_access_decoder (
        .cpu_req     (cpu_req),
        .dram_busy   (dram_busy),
        .dram_cmd    (dram_cmd),
        .slot_we     (slot_we),
        .slot_wdata  (slot_wdata),
        .slot_offset (slot_offset),
        .plic_we     (plic_we),
        .plic_re     (plic_re),
        .clint_we    (clint_we),
        .req_dev     (req_dev),
        .req_virt    (req_virt)
    );

    dram_load_aligner u_dram_load_aligner (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .dram_cmd   (dram_cmd),
        .dram_rdata (dram_rdata),
        .load_word  (load_word)
    );

    read_response_mux #(.N_SLOTS(N_SLOTS)) u_read_response_mux (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .req_dev     (req_dev),
        .req_virt    (req_virt),
        .dram_rdata  (dram_rdata),
        .slot_rdata  (slot_rdata),
        .plic_rdata  (plic_rdata),
        .clint_rdata (clint_rdata),
        .rdata       (rdata),
        .is_dram     (is_dram)
    );

    tohost_mailbox u_tohost_mailbox (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .uart_we   (uart_we),
        .uart_data (uart_data),
        .finish    (finish)
    );

    // CPU holds its request while DRAM or the UART transmitter is busy
    assign proc_busy = dram_busy || !uart_ready;

endmodule

//--- source/tohost_mailbox.sv
/* Tohost mailbox register. A print-char command gives a one-cycle UART byte
   pulse, a power-off command sets the sticky finish flag */
`timescale 1ns/1ns

module tohost_mailbox
    import interconnect_pkg::*;
(
    input  logic       CLK,
    input  logic       arst_n,
    input  cpu_req_t   cpu_req,
    output logic       uart_we,
    output logic [7:0] uart_data,
    output logic       finish
);

    data_t tohost_q;
    logic  tohost_store;
    logic  cmd_print;
    logic  cmd_power_off;

    assign tohost_store  = cpu_req.we && (cpu_req.addr == TOHOST_ADDR);
    assign cmd_print     = (tohost_q[31:16] == CMD_PRINT_CHAR);
    assign cmd_power_off = (tohost_q[31:16] == CMD_POWER_OFF);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            tohost_q  <= '0;
            uart_we   <= 1'b0;
            uart_data <= '0;
            finish    <= 1'b0;
        end else begin
            uart_we   <= 1'b0;
            uart_data <= '0;
            if (cmd_print) begin
                // Send the byte and free the mailbox on the same edge
                uart_we   <= 1'b1;
                uart_data <= tohost_q[7:0];
                tohost_q  <= '0;
            end else if (cmd_power_off) begin
                // Held until reset
                finish <= 1'b1;
            end else if (tohost_store) begin
                tohost_q <= cpu_req.wdata;
            end
        end
    end

    // A store that meets a pending command would be lost
    a_store_not_dropped: assert property (@(posedge CLK) disable iff (!arst_n)
        tohost_store |-> !(cmd_print || cmd_power_off))
        else $error("tohost store dropped, pending command %h", tohost_q[31:16]);

endmodule

//--- source/read_response_mux.sv
/* Registers the target of each access and returns the CPU read data
   one cycle later from DRAM, PLIC, CLINT or a virtio slot */
`timescale 1ns/1ns

module read_response_mux
    import interconnect_pkg::*;
#(
    parameter int N_SLOTS = 6
) (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  dev_t                 req_dev,
    input  virt_t                req_virt,
    input  line_t                dram_rdata,
    input  data_t [N_SLOTS-1:0]  slot_rdata,
    input  data_t                plic_rdata,
    input  data_t                clint_rdata,
    output line_t                rdata,
    output logic                 is_dram
);

    dev_t  dev_q;
    virt_t virt_q;
    data_t periph_word;

    // Target of the access in the previous cycle
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            dev_q  <= '0;
            virt_q <= '0;
        end else begin
            dev_q  <= req_dev;
            virt_q <= req_virt;
        end
    end

    always_comb begin
        periph_word = '0;
        is_dram     = 1'b0;
        case (dev_q)
            DEV_CLINT: periph_word = clint_rdata;
            DEV_PLIC:  periph_word = plic_rdata;
            DEV_VIRTIO: begin
                // Unpopulated slots read as zero
                if (int'(virt_q) < N_SLOTS) begin
                    periph_word = slot_rdata[virt_q];
                end
            end
            default: is_dram = 1'b1;
        endcase
    end

    // Full line for DRAM, zero-extended word otherwise
    assign rdata = is_dram ? dram_rdata : {96'b0, periph_word};

endmodule

//--- source/dram_load_aligner.sv
/* Captures offset and control of each DRAM access and extracts the
   sign or zero extended load word from the returned 128-bit line */
`timescale 1ns/1ns

module dram_load_aligner
    import interconnect_pkg::*;
(
    input  logic      CLK,
    input  logic      arst_n,
    input  dram_cmd_t dram_cmd,
    input  line_t     dram_rdata,
    output data_t     load_word
);

    logic [3:0] byte_off_q;
    ld_ctrl_t   ctrl_q;
    line_t      line_shifted;
    data_t      raw_word;
    logic       is_signed;

    // Byte offset within the line and funct3 of the last access
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            byte_off_q <= '0;
            ctrl_q     <= '0;
        end else if (dram_cmd.rd_en || dram_cmd.wr_en) begin
            byte_off_q <= dram_cmd.addr[3:0];
            ctrl_q     <= dram_cmd.ctrl;
        end
    end

    assign line_shifted = dram_rdata >> {byte_off_q, 3'b000};
    assign raw_word     = line_shifted[31:0];
    assign is_signed    = !ctrl_q[2];

    // lb/lbu, lh/lhu, lw
    always_comb begin
        case (ctrl_q[1:0])
            LD_SIZE_BYTE: load_word = {{24{raw_word[7] & is_signed}}, raw_word[7:0]};
            LD_SIZE_HALF: load_word = {{16{raw_word[15] & is_signed}}, raw_word[15:0]};
            default:      load_word = raw_word;
        endcase
    end

    // CPU never issues a size-3 (doubleword) access on RV32
    a_no_size3: assert property (@(posedge CLK) disable iff (!arst_n)
        ctrl_q[1:0] != 2'b11)
        else $error("captured ctrl with size 3: %b", ctrl_q);

endmodule

//--- source/access_decoder.sv
/* Combinational decode of a CPU data access into DRAM commands and
   peripheral, PLIC and CLINT strobes */
`timescale 1ns/1ns

module access_decoder
    import interconnect_pkg::*;
#(
    parameter int N_SLOTS = 6
) (
    input  cpu_req_t             cpu_req,
    input  logic                 dram_busy,
    output dram_cmd_t            dram_cmd,
    output logic [N_SLOTS-1:0]   slot_we,
    output data_t                slot_wdata,
    output addr_t                slot_offset,
    output logic                 plic_we,
    output logic                 plic_re,
    output logic                 clint_we,
    output dev_t                 req_dev,
    output virt_t                req_virt
);

    logic dram_hit;
    logic virtio_hit;

    // Address fields
    assign req_dev  = cpu_req.addr[31:28];
    assign req_virt = cpu_req.addr[27:24];

    assign dram_hit   = (req_dev == DEV_DRAM_LO) || (req_dev == DEV_DRAM_HI);
    assign virtio_hit = (req_dev == DEV_VIRTIO);

    // DRAM enables dropped while DRAM is busy
    always_comb begin
        dram_cmd.rd_en = cpu_req.re && dram_hit && !dram_busy;
        dram_cmd.wr_en = cpu_req.we && dram_hit && !dram_busy;
        dram_cmd.addr  = cpu_req.addr & DRAM_ADDR_MASK;
        dram_cmd.wdata = cpu_req.wdata;
        dram_cmd.ctrl  = cpu_req.ctrl;
    end

    // One strobe per virtio slot
    always_comb begin
        for (int i = 0; i < N_SLOTS; i++) begin
            slot_we[i] = cpu_req.we && virtio_hit && (req_virt == virt_t'(i));
        end
    end

    // Peripherals see the low 28 bits only
    assign slot_wdata  = cpu_req.wdata;
    assign slot_offset = {4'b0000, cpu_req.addr[27:0]};

    assign plic_we  = cpu_req.we && (req_dev == DEV_PLIC);
    assign plic_re  = cpu_req.re && (req_dev == DEV_PLIC);
    assign clint_we = cpu_req.we && (req_dev == DEV_CLINT);

endmodule

//--- source/interconnect_pkg.sv
/* Memory map, load/store control codes, tohost commands and bus types shared by
   the interconnect modules and the testbench */
package interconnect_pkg;

    // Meaningful widths
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  data_t;
    typedef logic [127:0] line_t;
    typedef logic [3:0]   dev_t;
    typedef logic [3:0]   virt_t;
    typedef logic [2:0]   ld_ctrl_t;

    // Device field values, address bits 31:28
    localparam dev_t DEV_DRAM_LO = 4'd0;
    localparam dev_t DEV_DRAM_HI = 4'd8;
    localparam dev_t DEV_VIRTIO  = 4'd4;
    localparam dev_t DEV_PLIC    = 4'd5;
    localparam dev_t DEV_CLINT   = 4'd6;

    // DRAM window is 128 MiB
    localparam addr_t DRAM_ADDR_MASK = 32'h07ff_ffff;
    localparam addr_t TOHOST_ADDR    = 32'h4000_8000;

    // Command codes in tohost bits 31:16, zero means idle
    localparam logic [15:0] CMD_PRINT_CHAR = 16'h0101;
    localparam logic [15:0] CMD_POWER_OFF  = 16'h0002;

    // RISC-V funct3 codes and size field of ld_ctrl_t
    localparam ld_ctrl_t    FUNCT3_LW    = 3'b010;
    localparam ld_ctrl_t    FUNCT3_SW    = 3'b010;
    localparam logic [1:0]  LD_SIZE_BYTE = 2'd0;
    localparam logic [1:0]  LD_SIZE_HALF = 2'd1;

    typedef struct packed {
        addr_t    addr;
        data_t    wdata;
        logic     we;
        logic     re;
        ld_ctrl_t ctrl;
    } cpu_req_t;

    typedef struct packed {
        logic     rd_en;
        logic     wr_en;
        addr_t    addr;
        data_t    wdata;
        ld_ctrl_t ctrl;
    } dram_cmd_t;

endpackage
